// File: list.f
calc_pkg.sv
calc_addsub.sv
calc_multiplier.sv
calc_control.sv
calc_bcd_display.sv
calc_top.sv
tb_calc.sv

// File: tb_calc.sv
// Directed testbench for the keypad calculator, checking results and BCD display
module tb_calc;
    timeunit 1ns;
    timeprecision 1ps;

    import calc_pkg::*;

    localparam int CLK_PERIOD   = 20;
    // Worst case is about 22 cycles per digit plus equals, compute and display
    localparam int DIGIT_CYCLES = 25;
    localparam int MAX_DIGITS   = 160;
    localparam int OP_CYCLES    = 60;
    localparam int MAX_OPS      = 30;
    localparam int WATCHDOG_NS  =
        (MAX_DIGITS * DIGIT_CYCLES + MAX_OPS * OP_CYCLES) * CLK_PERIOD;

    logic              clk;
    logic              nRST;
    digit_t            keypad_input;
    logic              read_input;
    op_t               operator_input;
    logic              equal_input;
    logic              busy;
    logic              complete;
    logic [CALC_W-1:0] result;
    bcd_digits_t       display_digits;
    logic              display_valid;

    int errors;
    int seed;

    calc_top uut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .result         (result),
        .display_digits (display_digits),
        .display_valid  (display_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // Reference model
    function automatic int unsigned model_result(int unsigned a, op_t op, int unsigned b);
        case (op)
            OP_ADD:  return (a + b) & 32'hFFFF;
            OP_SUB:  return (a - b) & 32'hFFFF;
            OP_MUL:  return (a * b) & 32'hFFFF;
            default: return 0;
        endcase
    endfunction

    // Operand after digit entry, wrapping at every step
    function automatic int unsigned entry_value(int unsigned n);
        int unsigned ds[$];
        int unsigned acc;
        acc = 0;
        do begin
            ds.push_front(n % 10);
            n = n / 10;
        end while (n != 0);
        foreach (ds[i]) begin
            acc = (acc * 10 + ds[i]) & 32'hFFFF;
        end
        return acc;
    endfunction

    function automatic bcd_digits_t decimal_digits(int unsigned v);
        bcd_digits_t d;
        for (int i = 0; i < DISP_DIGITS; i++) begin
            d[i] = digit_t'(v % 10);
            v = v / 10;
        end
        return d;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_value(string name, int unsigned expected, logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_digits(string name, bcd_digits_t expected, bcd_digits_t actual);
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < 100) begin
            tick();
            n++;
        end
        assert (!busy) else report_error("busy stayed high while waiting to enter input");
    endtask

    task automatic enter_digit(int unsigned d);
        wait_idle();
        keypad_input = digit_t'(d);
        read_input   = 1'b1;
        tick();
        read_input   = 1'b0;
    endtask

    task automatic enter_number(int unsigned n);
        int unsigned ds[$];
        do begin
            ds.push_front(n % 10);
            n = n / 10;
        end while (n != 0);
        foreach (ds[i]) begin
            enter_digit(ds[i]);
        end
    endtask

    task automatic select_operator(op_t op);
        wait_idle();
        operator_input = op;
        tick();
        operator_input = OP_NONE;
    endtask

    task automatic press_equals();
        wait_idle();
        equal_input = 1'b1;
        tick();
        equal_input = 1'b0;
    endtask

    // Waits for complete, then the display update 17 cycles later
    task automatic finish_op(string name, int unsigned expected);
        int n;
        n = 0;
        while (!complete && n < 100) begin
            tick();
            n++;
        end
        assert (complete) else report_error({name, ": no complete pulse after equals"});
        check_value(name, expected, result);
        n = 0;
        while (!display_valid && n < 40) begin
            tick();
            n++;
        end
        assert (display_valid) else report_error({name, ": display_valid never pulsed"});
        check_value({name, " display latency"}, 17, n);
        check_digits({name, " display"}, decimal_digits(expected), display_digits);
    endtask

    task automatic run_op(string name, int unsigned a, op_t op, int unsigned b);
        enter_number(a);
        select_operator(op);
        enter_number(b);
        press_equals();
        finish_op(name, model_result(entry_value(a), op, entry_value(b)));
    endtask

    task automatic test_reset();
        check_value("test_reset busy", 0, busy);
        check_value("test_reset complete", 0, complete);
        check_value("test_reset display_valid", 0, display_valid);
        check_value("test_reset result", 0, result);
        check_digits("test_reset display_digits", '0, display_digits);
    endtask

    task automatic test_add_sub();
        run_op("test_add_sub 123+456", 123, OP_ADD, 456);
        run_op("test_add_sub 900-37", 900, OP_SUB, 37);
        run_op("test_add_sub 5-9", 5, OP_SUB, 9);
        run_op("test_add_sub 60000+10000", 60000, OP_ADD, 10000);
    endtask

    task automatic test_multiply();
        int unsigned a;
        int unsigned b;
        op_t         op;
        run_op("test_multiply 250x12", 250, OP_MUL, 12);
        run_op("test_multiply 1000x1000", 1000, OP_MUL, 1000);
        for (int i = 0; i < 10; i++) begin
            a = {$random(seed)} % 1000;
            b = {$random(seed)} % 1000;
            case ({$random(seed)} % 3)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                default: op = OP_MUL;
            endcase
            run_op($sformatf("test_multiply random %0d", i), a, op, b);
        end
    endtask

    task automatic test_entry_rules();
        // Keypad code 12 must not start a digit step
        enter_digit(4);
        wait_idle();
        keypad_input = digit_t'(12);
        read_input   = 1'b1;
        tick();
        read_input   = 1'b0;
        check_value("test_entry_rules keypad 12 busy", 0, busy);
        enter_digit(5);
        select_operator(OP_ADD);
        enter_number(1);
        press_equals();
        finish_op("test_entry_rules keypad 12", 46);

        // Second strobe lands while busy
        wait_idle();
        keypad_input = digit_t'(7);
        read_input   = 1'b1;
        tick();
        check_value("test_entry_rules busy after digit", 1, busy);
        keypad_input = digit_t'(3);
        tick();
        read_input   = 1'b0;
        select_operator(OP_ADD);
        enter_number(1);
        press_equals();
        finish_op("test_entry_rules dropped strobe", 8);

        run_op("test_entry_rules 6 digits", 987654, OP_ADD, 0);
    endtask

    task automatic test_display();
        run_op("test_display 65535", 65535, OP_ADD, 0);
        run_op("test_display 0", 7, OP_SUB, 7);
        run_op("test_display 40005", 40000, OP_ADD, 5);
    endtask

    initial begin
        errors         = 0;
        seed           = 54900;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        nRST = 1'b1;
        tick();

        test_reset();
        test_add_sub();
        test_multiply();
        test_entry_rules();
        test_display();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: calc_top.sv
// Calculator top level joining the controller, both arithmetic units and the display
module calc_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::digit_t            keypad_input,
    input  logic                        read_input,
    input  calc_pkg::op_t               operator_input,
    input  logic                        equal_input,
    output logic                        busy,
    output logic                        complete,
    output logic [calc_pkg::CALC_W-1:0] result,
    output calc_pkg::bcd_digits_t       display_digits,
    output logic                        display_valid
);
    import calc_pkg::*;

    arith_req_t        mult_req;
    arith_req_t        alu_req;
    logic              mult_start;
    logic              mult_finish;
    logic              alu_start;
    logic              alu_finish;
    logic [CALC_W-1:0] mult_out;
    logic [CALC_W-1:0] alu_out;

    calc_control u_control (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .mult_req       (mult_req),
        .mult_start     (mult_start),
        .mult_out       (mult_out),
        .mult_finish    (mult_finish),
        .alu_req        (alu_req),
        .alu_start      (alu_start),
        .alu_out        (alu_out),
        .alu_finish     (alu_finish),
        .busy           (busy),
        .complete       (complete),
        .result         (result)
    );

    calc_addsub u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .req    (alu_req),
        .start  (alu_start),
        .out    (alu_out),
        .finish (alu_finish)
    );

    calc_multiplier u_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .req    (mult_req),
        .start  (mult_start),
        .out    (mult_out),
        .finish (mult_finish)
    );

    // Each new result is converted for the display
    calc_bcd_display u_display (
        .clk    (clk),
        .nRST   (nRST),
        .start  (complete),
        .value  (result),
        .digits (display_digits),
        .valid  (display_valid)
    );

endmodule

// File: calc_bcd_display.sv
// Double-dabble converter from a binary result to BCD display digits
module calc_bcd_display (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  logic [calc_pkg::CALC_W-1:0] value,
    output calc_pkg::bcd_digits_t       digits,
    output logic                        valid
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(CALC_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(CALC_W - 1);
    localparam int BCD_W = $bits(bcd_digits_t);

    logic              running;
    logic [CNT_W-1:0]  step;
    logic [CALC_W-1:0] bin_sh;
    bcd_digits_t       work;
    bcd_digits_t       adj;
    bcd_digits_t       work_next;
    logic [BCD_W-1:0]  adj_flat;

    // Add three to every digit of five or more
    always_comb begin
        adj = work;
        for (int i = 0; i < DISP_DIGITS; i++) begin
            if (adj[i] >= 4'd5) begin
                adj[i] = adj[i] + 4'd3;
            end
        end
    end

    // Then shift in the next binary bit
    assign adj_flat  = adj;
    assign work_next = {adj_flat[BCD_W-2:0], bin_sh[CALC_W-1]};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            step    <= '0;
            valid   <= 1'b0;
            digits  <= '0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    running <= 1'b0;
                    valid   <= 1'b1;
                    digits  <= work_next;
                end
            end
        end
    end

    // Working registers, reloaded on every start
    always_ff @(posedge clk) begin
        if (start) begin
            bin_sh <= value;
            work   <= '0;
        end else if (running) begin
            bin_sh <= bin_sh << 1;
            work   <= work_next;
        end
    end

endmodule

// File: calc_control.sv
// Keypad entry and operation sequencer sharing the multiplier between digit entry and multiply
module calc_control (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::digit_t            keypad_input,
    input  logic                        read_input,
    input  calc_pkg::op_t               operator_input,
    input  logic                        equal_input,
    output calc_pkg::arith_req_t        mult_req,
    output logic                        mult_start,
    input  logic [calc_pkg::CALC_W-1:0] mult_out,
    input  logic                        mult_finish,
    output calc_pkg::arith_req_t        alu_req,
    output logic                        alu_start,
    input  logic [calc_pkg::CALC_W-1:0] alu_out,
    input  logic                        alu_finish,
    output logic                        busy,
    output logic                        complete,
    output logic [calc_pkg::CALC_W-1:0] result
);
    import calc_pkg::*;

    localparam logic [CALC_W-1:0] TEN = CALC_W'(10);

    typedef enum logic [1:0] {
        ST_ENTRY = 2'b00,
        ST_SCALE = 2'b01,
        ST_FOLD  = 2'b10,
        ST_CALC  = 2'b11
    } state_t;

    state_t            state;
    logic              entry_b;
    logic [CALC_W-1:0] op_a;
    logic [CALC_W-1:0] op_b;
    op_t               op_q;
    op_t               op_sel;
    digit_t            digit_q;
    logic              digit_ok;
    logic              take_digit;
    logic              take_op;
    logic              take_eq;
    logic [CALC_W-1:0] entry_operand;
    logic              unit_finish;
    logic [CALC_W-1:0] unit_out;

    // Undefined operator codes count as no operator
    always_comb begin
        case (operator_input)
            OP_ADD, OP_SUB, OP_MUL: op_sel = operator_input;
            default:                op_sel = OP_NONE;
        endcase
    end

    assign digit_ok = read_input && (keypad_input <= 4'd9);

    // Entry decisions, equals wins over a digit in operand B
    assign take_eq    = (state == ST_ENTRY) && entry_b && equal_input;
    assign take_digit = (state == ST_ENTRY) && digit_ok && !take_eq;
    assign take_op    = (state == ST_ENTRY) && !entry_b && !digit_ok && (op_sel != OP_NONE);

    assign entry_operand = entry_b ? op_b : op_a;

    // Unit chosen by the latched operator
    assign unit_finish = (op_q == OP_MUL) ? mult_finish : alu_finish;
    assign unit_out    = (op_q == OP_MUL) ? mult_out : alu_out;

    assign busy = (state != ST_ENTRY);

    // Requests stay put until the unit finishes
    always_ff @(posedge clk) begin
        if (take_digit) begin
            digit_q  <= keypad_input;
            mult_req <= '{a: entry_operand, b: TEN, sub: 1'b0};
        end else if (take_eq && (op_q == OP_MUL)) begin
            mult_req <= '{a: op_a, b: op_b, sub: 1'b0};
        end
        if (take_eq && (op_q != OP_MUL)) begin
            alu_req <= '{a: op_a, b: op_b, sub: (op_q == OP_SUB)};
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ST_ENTRY;
            entry_b    <= 1'b0;
            op_a       <= '0;
            op_b       <= '0;
            op_q       <= OP_NONE;
            mult_start <= 1'b0;
            alu_start  <= 1'b0;
            complete   <= 1'b0;
            result     <= '0;
        end else begin
            mult_start <= take_digit || (take_eq && (op_q == OP_MUL));
            alu_start  <= take_eq && (op_q != OP_MUL);
            complete   <= 1'b0;

            case (state)
                ST_ENTRY: begin
                    if (take_eq) begin
                        state <= ST_CALC;
                    end else if (take_digit) begin
                        state <= ST_SCALE;
                    end else if (take_op) begin
                        op_q    <= op_sel;
                        entry_b <= 1'b1;
                    end
                end

                // Operand times ten
                ST_SCALE: begin
                    if (mult_finish) begin
                        if (entry_b) begin
                            op_b <= mult_out;
                        end else begin
                            op_a <= mult_out;
                        end
                        state <= ST_FOLD;
                    end
                end

                // Add in the latched digit
                ST_FOLD: begin
                    if (entry_b) begin
                        op_b <= op_b + CALC_W'(digit_q);
                    end else begin
                        op_a <= op_a + CALC_W'(digit_q);
                    end
                    state <= ST_ENTRY;
                end

                ST_CALC: begin
                    if (unit_finish) begin
                        complete <= 1'b1;
                        result   <= unit_out;
                        op_a     <= '0;
                        op_b     <= '0;
                        op_q     <= OP_NONE;
                        entry_b  <= 1'b0;
                        state    <= ST_ENTRY;
                    end
                end

                default: state <= ST_ENTRY;
            endcase
        end
    end

endmodule

// File: calc_multiplier.sv
// Shift-and-add multiplier, one multiplier bit per cycle, low word of the product
module calc_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::arith_req_t        req,
    input  logic                        start,
    output logic [calc_pkg::CALC_W-1:0] out,
    output logic                        finish
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(CALC_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(CALC_W - 1);

    logic              running;
    logic [CNT_W-1:0]  step;
    logic [CALC_W-1:0] mcand;
    logic [CALC_W-1:0] mplier;
    logic [CALC_W-1:0] acc;
    logic [CALC_W-1:0] acc_next;

    // Partial product for the current multiplier bit
    assign acc_next = mplier[0] ? (acc + mcand) : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            step    <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (!running) begin
                if (start) begin
                    running <= 1'b1;
                    step    <= '0;
                end
            end else begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    // Shift registers and accumulator
    always_ff @(posedge clk) begin
        if (!running && start) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (running) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
            // Product is final after the last bit
            if (step == LAST_STEP) begin
                out <= acc_next;
            end
        end
    end

endmodule

// File: calc_addsub.sv
// Add/subtract unit, one registered stage from start to finish
module calc_addsub (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::arith_req_t        req,
    input  logic                        start,
    output logic [calc_pkg::CALC_W-1:0] out,
    output logic                        finish
);
    import calc_pkg::*;

    logic [CALC_W-1:0] sum;

    // Wraps modulo 2^CALC_W in both directions
    assign sum = req.sub ? (req.a - req.b) : (req.a + req.b);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (start) begin
            out <= sum;
        end
    end

endmodule

// File: calc_pkg.sv
// Calculator shared definitions for operand width, operator codes and display digits
package calc_pkg;

    // Operand and result width
    localparam int CALC_W = 16;

    // Number of BCD digits shown
    localparam int DISP_DIGITS = 5;

    // One decimal digit or raw keypad code
    typedef logic [3:0] digit_t;

    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } op_t;

    // Operand pair for either arithmetic unit, sub is only read by the adder
    typedef struct packed {
        logic [CALC_W-1:0] a;
        logic [CALC_W-1:0] b;
        logic              sub;
    } arith_req_t;

    // Most significant digit at the highest index
    typedef digit_t [DISP_DIGITS-1:0] bcd_digits_t;

endpackage
